// ==== include/bp_macros.svh ====
`ifndef BP_MACROS_SVH
`define BP_MACROS_SVH

// word width, also the widest code accepted
// must stay a power of two for the fifo pointer wrap
`define BP_WORD_W 16

// number of independent lanes
`define BP_LANES 4

// bit capacity of each lane fifo
`define BP_BUF_W (2 * `BP_WORD_W)

`endif

// ==== verilog/bp_pkg.sv ====
`include "bp_macros.svh"

package bp_pkg;

   // code or read width, 0 up to a full word
   typedef logic [$clog2(`BP_WORD_W):0] width_t;

   // bits stored or free in one lane
   typedef logic [$clog2(`BP_BUF_W):0] level_t;

   // lane number
   typedef logic [$clog2(`BP_LANES)-1:0] lane_t;

   // one word of payload
   // codes sit MSB aligned in it
   typedef logic [`BP_WORD_W-1:0] word_t;

endpackage

// ==== verilog/bit_fifo.sv ====
`timescale 1ns/1ps
`include "bp_macros.svh"

module bit_fifo (
   input  logic           clk_i,
   input  logic           reset_i,

   input  logic           write_i,
   input  bp_pkg::width_t wwidth_i,
   input  bp_pkg::word_t  wdata_i,
   output bp_pkg::level_t wlevel_o,

   input  logic           read_i,
   input  bp_pkg::width_t rwidth_i,
   output bp_pkg::word_t  rdata_o,
   output bp_pkg::level_t rlevel_o
);

   import bp_pkg::*;

   localparam int unsigned ptr_w = $clog2(`BP_BUF_W);
   localparam int unsigned cw_w = $clog2(`BP_WORD_W);

   typedef logic [ptr_w-1:0] ptr_t;
   typedef logic [`BP_BUF_W-1:0] buf_t;
   typedef logic [cw_w-1:0] cw_t;

   // buffer position p lives at data[BP_BUF_W-1-p]
   buf_t   data;
   ptr_t   rptr;
   ptr_t   wptr;
   level_t level;

   // complemented widths, zero for a full word
   cw_t    crwidth;
   cw_t    cwwidth;

   word_t  wdata_m;
   buf_t   wbits;
   buf_t   keep_mask;
   buf_t   rd_rot;

   // rotate towards the MSB
   function automatic buf_t rot_left(buf_t x, ptr_t s);
      logic [2*`BP_BUF_W-1:0] d;
      d = {x, x} << s;
      return d[2*`BP_BUF_W-1 -: `BP_BUF_W];
   endfunction

   // rotate towards the LSB
   function automatic buf_t rot_right(buf_t x, ptr_t s);
      logic [2*`BP_BUF_W-1:0] d;
      d = {x, x} >> s;
      return d[`BP_BUF_W-1:0];
   endfunction

   assign crwidth = ~rwidth_i[cw_w-1:0] + 1'b1;
   assign cwwidth = ~wwidth_i[cw_w-1:0] + 1'b1;

   assign wlevel_o = level_t'(`BP_BUF_W) - level;
   assign rlevel_o = level;

   // keep only the top wwidth_i bits of the code
   assign wdata_m = (wdata_i >> cwwidth) << cwwidth;

   // code placed at the write pointer
   assign wbits = rot_right({wdata_m, {`BP_WORD_W{1'b0}}}, wptr);

   // zeros over the positions about to be written
   assign keep_mask = rot_right({`BP_BUF_W{1'b1}} >> wwidth_i, wptr);

   // oldest bit moved to the top
   assign rd_rot = rot_left(data, rptr);

   // clear the bits past the read width
   assign rdata_o = (rd_rot[`BP_BUF_W-1 -: `BP_WORD_W] >> crwidth) << crwidth;

   // pointers and level, read wins over write
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         rptr  <= '0;
         wptr  <= '0;
         level <= '0;
      end else if (read_i) begin
         rptr  <= rptr + ptr_t'(rwidth_i);
         level <= level - level_t'(rwidth_i);
      end else if (write_i) begin
         wptr  <= wptr + ptr_t'(wwidth_i);
         level <= level + level_t'(wwidth_i);
      end
   end

   // bit storage
   always_ff @(posedge clk_i) begin
      if (write_i && !read_i) begin
         data <= (data & keep_mask) | wbits;
      end
   end

endmodule

// ==== verilog/code_router.sv ====
`timescale 1ns/1ps
`include "bp_macros.svh"

module code_router (
   input  logic                                 clk_i,
   input  logic                                 reset_i,

   input  logic                                 code_valid_i,
   input  bp_pkg::lane_t                        code_lane_i,
   input  bp_pkg::width_t                       code_width_i,
   input  bp_pkg::word_t                        code_data_i,

   // free bits of every lane
   input  bp_pkg::level_t [`BP_LANES-1:0]       lane_free_i,

   output logic [`BP_LANES-1:0]                 fifo_write_o,
   output bp_pkg::width_t                       fifo_wwidth_o,
   output bp_pkg::word_t                        fifo_wdata_o,
   output logic                                 drop_o
);

   import bp_pkg::*;

   logic   code_vld_q;
   lane_t  lane_q;
   width_t width_q;
   word_t  data_q;

   logic   fits;

   // strobe delayed by one cycle
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         code_vld_q <= 1'b0;
      end else begin
         code_vld_q <= code_valid_i;
      end
   end

   // payload captured with the strobe
   always_ff @(posedge clk_i) begin
      if (code_valid_i) begin
         lane_q  <= code_lane_i;
         width_q <= code_width_i;
         data_q  <= code_data_i;
      end
   end

   // space check against the addressed lane
   assign fits = level_t'(width_q) <= lane_free_i[lane_q];

   // only the addressed lane sees a write
   always_comb begin
      fifo_write_o = '0;
      if (code_vld_q && fits) begin
         fifo_write_o[lane_q] = 1'b1;
      end
   end

   // shared by every lane
   assign fifo_wwidth_o = width_q;
   assign fifo_wdata_o  = data_q;

   // code lost for lack of room
   assign drop_o = code_vld_q && !fits;

endmodule

// ==== verilog/word_collector.sv ====
`timescale 1ns/1ps
`include "bp_macros.svh"

module word_collector (
   input  logic                            clk_i,
   input  logic                            reset_i,

   // stored bits and head word of every lane
   input  bp_pkg::level_t [`BP_LANES-1:0]  lane_level_i,
   input  bp_pkg::word_t  [`BP_LANES-1:0]  lane_data_i,
   // lanes being written this cycle
   input  logic [`BP_LANES-1:0]            lane_write_i,

   output logic [`BP_LANES-1:0]            fifo_read_o,

   output logic                            word_valid_o,
   output bp_pkg::lane_t                   word_lane_o,
   output bp_pkg::word_t                   word_o
);

   import bp_pkg::*;

   logic [`BP_LANES-1:0] eligible;

   // last lane served
   lane_t last_q;

   lane_t cand;
   lane_t pick;
   logic  pick_vld;

   // a full word waiting and no write in flight
   always_comb begin
      for (int i = 0; i < `BP_LANES; i++) begin
         eligible[i] = (lane_level_i[i] >= level_t'(`BP_WORD_W)) && !lane_write_i[i];
      end
   end

   // round robin scan, starting right after the last served lane
   always_comb begin
      pick_vld = 1'b0;
      pick     = last_q;
      cand     = last_q;
      for (int k = 1; k <= `BP_LANES; k++) begin
         cand = last_q + lane_t'(k);
         if (!pick_vld && eligible[cand]) begin
            pick_vld = 1'b1;
            pick     = cand;
         end
      end
   end

   always_comb begin
      fifo_read_o = '0;
      if (pick_vld) begin
         fifo_read_o[pick] = 1'b1;
      end
   end

   // pointer and output strobe
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         last_q       <= lane_t'(`BP_LANES - 1);
         word_valid_o <= 1'b0;
      end else begin
         word_valid_o <= pick_vld;
         if (pick_vld) begin
            last_q <= pick;
         end
      end
   end

   // head word captured while the read takes effect
   always_ff @(posedge clk_i) begin
      if (pick_vld) begin
         word_lane_o <= pick;
         word_o      <= lane_data_i[pick];
      end
   end

endmodule

// ==== verilog/bit_packer_top.sv ====
`timescale 1ns/1ps
`include "bp_macros.svh"

module bit_packer_top (
   input  logic           clk_i,
   input  logic           reset_i,

   input  logic           code_valid_i,
   input  bp_pkg::lane_t  code_lane_i,
   input  bp_pkg::width_t code_width_i,
   input  bp_pkg::word_t  code_data_i,

   output logic           word_valid_o,
   output bp_pkg::lane_t  word_lane_o,
   output bp_pkg::word_t  word_o,
   output logic           drop_o
);

   import bp_pkg::*;

   // write side, width and data shared by all lanes
   logic [`BP_LANES-1:0]   fifo_write;
   width_t                 fifo_wwidth;
   word_t                  fifo_wdata;
   level_t [`BP_LANES-1:0] fifo_wlevel;

   // read side
   logic [`BP_LANES-1:0]   fifo_read;
   width_t                 fifo_rwidth;
   level_t [`BP_LANES-1:0] fifo_rlevel;
   word_t  [`BP_LANES-1:0] fifo_rdata;

   // collector always takes whole words
   assign fifo_rwidth = width_t'(`BP_WORD_W);

   code_router i_router (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .code_valid_i (code_valid_i),
      .code_lane_i  (code_lane_i),
      .code_width_i (code_width_i),
      .code_data_i  (code_data_i),
      .lane_free_i  (fifo_wlevel),
      .fifo_write_o (fifo_write),
      .fifo_wwidth_o(fifo_wwidth),
      .fifo_wdata_o (fifo_wdata),
      .drop_o       (drop_o)
   );

   for (genvar i = 0; i < `BP_LANES; i++) begin : g_lane
      bit_fifo i_fifo (
         .clk_i   (clk_i),
         .reset_i (reset_i),
         .write_i (fifo_write[i]),
         .wwidth_i(fifo_wwidth),
         .wdata_i (fifo_wdata),
         .wlevel_o(fifo_wlevel[i]),
         .read_i  (fifo_read[i]),
         .rwidth_i(fifo_rwidth),
         .rdata_o (fifo_rdata[i]),
         .rlevel_o(fifo_rlevel[i])
      );
   end

   word_collector i_collector (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .lane_level_i(fifo_rlevel),
      .lane_data_i (fifo_rdata),
      .lane_write_i(fifo_write),
      .fifo_read_o (fifo_read),
      .word_valid_o(word_valid_o),
      .word_lane_o (word_lane_o),
      .word_o      (word_o)
   );

endmodule

// ==== test/bit_packer_checker.sv ====
`timescale 1ns/1ps
`include "bp_macros.svh"

module bit_packer_checker (
   input  logic          clk_i,
   input  logic          code_valid_i,
   input  logic          word_valid_i,
   input  bp_pkg::lane_t word_lane_i,
   input  bp_pkg::word_t word_i,
   input  logic          drop_i
);

   import bp_pkg::*;

   int   word_errors = 0;
   int   drop_errors = 0;
   int   words_seen = 0;

   // a code went into the router at the last rising edge
   logic code_seen = 1'b0;

   always @(posedge clk_i) begin
      code_seen <= code_valid_i;
   end

   // outputs are registered, stable at the falling edge
   always @(negedge clk_i) begin : compare
      word_t exp_word;
      bit    exp_drop;
      if (word_valid_i === 1'b1) begin
         words_seen++;
         if (bit_packer_tb.queued_bits(int'(word_lane_i)) < `BP_WORD_W) begin
            $display("error: word on lane %0d, which holds less than a full word",
                     word_lane_i);
            word_errors++;
         end else begin
            exp_word = bit_packer_tb.next_word(int'(word_lane_i));
            if (word_i !== exp_word) begin
               $display("mismatch word_o lane %0d: got %h expected %h",
                        word_lane_i, word_i, exp_word);
               word_errors++;
            end
         end
      end

      if (code_seen) begin
         exp_drop = bit_packer_tb.next_drop();
         if (drop_i !== exp_drop) begin
            $display("mismatch drop_o: got %h expected %h", drop_i, exp_drop);
            drop_errors++;
         end
      end else if (drop_i !== 1'b0) begin
         $display("error: drop_o pulsed with no code in the router");
         drop_errors++;
      end
   end

endmodule

// ==== test/bit_packer_tb.sv ====
`timescale 1ns/1ps
`include "bp_macros.svh"

module bit_packer_tb;

   import bp_pkg::*;

   logic   clk_i;
   logic   reset_i;
   logic   code_valid_i;
   lane_t  code_lane_i;
   width_t code_width_i;
   word_t  code_data_i;

   logic   word_valid_o;
   lane_t  word_lane_o;
   word_t  word_o;
   logic   drop_o;

   // accepted bits per lane, oldest first
   bit bits_q [`BP_LANES][$];
   // one entry per code sent, set when a drop is expected
   bit drop_q [$];
   // predicted fill of each lane while codes stream in
   int lvl [`BP_LANES];

   int other_errors = 0;
   int drops_expected = 0;
   int total_errors;

   bit_packer_top i_dut (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .code_valid_i(code_valid_i),
      .code_lane_i (code_lane_i),
      .code_width_i(code_width_i),
      .code_data_i (code_data_i),
      .word_valid_o(word_valid_o),
      .word_lane_o (word_lane_o),
      .word_o      (word_o),
      .drop_o      (drop_o)
   );

   bit_packer_checker i_chk (
      .clk_i       (clk_i),
      .code_valid_i(code_valid_i),
      .word_valid_i(word_valid_o),
      .word_lane_i (word_lane_o),
      .word_i      (word_o),
      .drop_i      (drop_o)
   );

   initial begin
      clk_i = 1'b0;
      forever begin
         #50 clk_i = ~clk_i;
      end
   end

   // next full word of a lane, first bit sent lands in the MSB
   function automatic word_t next_word(input int lane);
      word_t w;
      w = '0;
      for (int k = `BP_WORD_W - 1; k >= 0; k--) begin
         if (bits_q[lane].size() > 0) begin
            w[k] = bits_q[lane].pop_front();
         end
      end
      return w;
   endfunction

   function automatic int queued_bits(input int lane);
      return bits_q[lane].size();
   endfunction

   function automatic bit next_drop();
      return drop_q.pop_front();
   endfunction

   function automatic void sync_levels();
      for (int l = 0; l < `BP_LANES; l++) begin
         lvl[l] = bits_q[l].size();
      end
   endfunction

   // called right after a falling edge
   task automatic drive_code(input int lane, input int width, input word_t data);
      bit fits;
      fits = width <= `BP_BUF_W - lvl[lane];
      code_valid_i = 1'b1;
      code_lane_i  = lane_t'(lane);
      code_width_i = width_t'(width);
      code_data_i  = data;
      drop_q.push_back(!fits);
      if (fits) begin
         for (int k = 0; k < width; k++) begin
            bits_q[lane].push_back(data[`BP_WORD_W - 1 - k]);
         end
         lvl[lane] += width;
      end else begin
         drops_expected++;
         // no write in the drop cycle, so the collector takes a word
         if (lvl[lane] >= `BP_WORD_W) begin
            lvl[lane] -= `BP_WORD_W;
         end
      end
   endtask

   // one code every five cycles, random lane when fixed_lane is negative
   task automatic send_spaced(input int count, input int fixed_lane);
      int lane;
      for (int n = 0; n < count; n++) begin
         @(negedge clk_i);
         sync_levels();
         if (fixed_lane < 0) begin
            lane = $urandom_range(`BP_LANES - 1, 0);
         end else begin
            lane = fixed_lane;
         end
         drive_code(lane, $urandom_range(`BP_WORD_W, 1), word_t'($urandom));
         @(negedge clk_i);
         code_valid_i = 1'b0;
         repeat (3) @(negedge clk_i);
      end
   endtask

   // back to back codes on one lane
   task automatic send_burst(input int count, input int lane);
      for (int n = 0; n < count; n++) begin
         @(negedge clk_i);
         drive_code(lane, $urandom_range(`BP_WORD_W, 1), word_t'($urandom));
      end
      @(negedge clk_i);
      code_valid_i = 1'b0;
   endtask

   task automatic wait_drain(input int limit);
      int  cycles;
      bit  done;
      cycles = 0;
      done   = 1'b0;
      while (!done && cycles < limit) begin
         @(negedge clk_i);
         cycles++;
         done = 1'b1;
         for (int l = 0; l < `BP_LANES; l++) begin
            if (bits_q[l].size() >= `BP_WORD_W) begin
               done = 1'b0;
            end
         end
      end
      if (!done) begin
         $display("error: lanes still hold full words after %0d cycles", limit);
         other_errors++;
      end
   endtask

   task automatic check_leftover();
      level_t got;
      for (int l = 0; l < `BP_LANES; l++) begin
         got = i_dut.fifo_rlevel[l];
         if (int'(got) != bits_q[l].size()) begin
            $display("mismatch fifo_rlevel[%0d]: got %h expected %h",
                     l, got, bits_q[l].size());
            other_errors++;
         end
      end
   endtask

   initial begin
      void'($urandom(32'hf213aeb7));
      reset_i      = 1'b1;
      code_valid_i = 1'b0;
      code_lane_i  = '0;
      code_width_i = '0;
      code_data_i  = '0;
      sync_levels();
      repeat (4) @(negedge clk_i);
      reset_i = 1'b0;

      // quiet period, the checker flags any word or drop
      repeat (10) @(negedge clk_i);

      send_spaced(40, 1);
      wait_drain(100);
      send_spaced(80, -1);
      wait_drain(100);

      // overflow on lane 2 while it is written every cycle
      sync_levels();
      send_burst(40, 2);
      if (drops_expected == 0) begin
         $display("error: the burst on lane 2 provoked no drop");
         other_errors++;
      end
      wait_drain(200);

      // nothing more may come out once the lanes drained
      repeat (20) @(negedge clk_i);
      check_leftover();

      total_errors = i_chk.word_errors + i_chk.drop_errors + other_errors;
      $display("errors: word %0d, drop %0d, other %0d (words seen %0d)",
               i_chk.word_errors, i_chk.drop_errors, other_errors, i_chk.words_seen);
      if (total_errors == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

// ==== list.f ====
+incdir+include
verilog/bp_pkg.sv
verilog/bit_fifo.sv
verilog/code_router.sv
verilog/word_collector.sv
verilog/bit_packer_top.sv
test/bit_packer_checker.sv
test/bit_packer_tb.sv

// ==== Bender.yml ====
package:
  name: bit_packer

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/bp_pkg.sv
      - verilog/bit_fifo.sv
      - verilog/code_router.sv
      - verilog/word_collector.sv
      - verilog/bit_packer_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/bit_packer_checker.sv
      - test/bit_packer_tb.sv
